//--- source/game_io_defs.svh
// game_io shared constants.
// Register addresses of the CPU memory map, VGA line and frame lengths
// and the depth of the board input synchronizer.

`ifndef GAME_IO_DEFS_SVH
`define GAME_IO_DEFS_SVH

// Memory map, top of the 16-bit address space.
`define SW_ADDR          16'hFFFF
`define KEY_ADDR         16'hFFFE
`define LEDR_ADDR        16'hFFFD
`define HEX_H_ADDR       16'hFFFC
`define HEX_L_ADDR       16'hFFFB
`define VGA_HCOUNT_ADDR  16'hFFFA
`define VGA_VCOUNT_ADDR  16'hFFF9
`define MUSIC_CTRL_ADDR  16'hFFF8
`define DRUMPAD_ADDR     16'hFFF7

// 640x480 timing, blanking included.
`define VGA_H_TOTAL      800
`define VGA_V_TOTAL      525

// Flip-flop stages between a board pin and the register map.
`define SYNC_STAGES      2

`endif

//--- source/bus_pkg.sv
// CPU memory port types.
// One access is an address, a write enable and write data, all presented
// in the same cycle; read data comes back combinationally.

package bus_pkg;

  typedef logic [15:0] addr_t;       // Byte-free word address.
  typedef logic [15:0] data_word_t;  // One bus data word.

  // A single CPU access. Reads are implied whenever wr_en is low.
  typedef struct packed {
    addr_t      addr;
    logic       wr_en;
    data_word_t wr_data;
  } mem_req_t;

endpackage

//--- source/board_pkg.sv
// Board-facing types.
// Field widths of the switches, keys, drum pads, LEDs and displays, plus
// the grouped input and output structs that travel between the blocks.

package board_pkg;

  typedef logic [3:0]  hex_digit_t;   // Value shown on one display.
  typedef logic [6:0]  seg7_t;        // Active low, bit 0 is segment a.
  typedef logic [9:0]  led_t;
  typedef logic [9:0]  switch_t;
  typedef logic [3:0]  key_t;
  typedef logic [3:0]  drumpad_t;
  typedef logic [1:0]  music_ctrl_t;  // Control bits for the synthesizer.
  typedef logic [15:0] scan_count_t;  // Beam position in pixels or lines.

  // Everything read from the board pins.
  typedef struct packed {
    switch_t  sw;
    key_t     key;
    drumpad_t drumpad;
  } board_in_t;

  // Everything driven onto the board.
  typedef struct packed {
    led_t        ledr;
    seg7_t       hex5;
    seg7_t       hex4;
    seg7_t       hex3;
    seg7_t       hex2;
    seg7_t       hex1;
    seg7_t       hex0;
    music_ctrl_t music_ctrl;
  } board_out_t;

endpackage

//--- source/hex_to_seg7.sv
// Hex digit to seven-segment decoder.
// Maps 0-F onto the usual hexadecimal glyphs for an active-low display.

module hex_to_seg7 (
  input  board_pkg::hex_digit_t digit,
  output board_pkg::seg7_t      seg
);

  // Patterns are listed g down to a.
  always_comb begin
    case (digit)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;  // Lower case b.
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;  // Lower case d.
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;  // F.
    endcase
  end

endmodule

//--- source/input_sync.sv
// Board input synchronizer.
// Switches, keys and drum pads change with no relation to clk, so the
// whole input struct passes through a short chain of flip-flops before
// the register map can read it.

`include "game_io_defs.svh"

module input_sync (
  input  logic                 clk,
  input  logic                 reset_n,
  input  board_pkg::board_in_t raw,
  output board_pkg::board_in_t synced
);

  import board_pkg::*;

  board_in_t stage_q [`SYNC_STAGES];  // Stage 0 samples the pins.

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= raw;  // May go metastable, settles before the next edge.
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign synced = stage_q[`SYNC_STAGES-1];  // Last stage feeds the read mux.

endmodule

//--- source/vga_scan_counter.sv
// VGA scan position counter.
// Tracks the beam over a full 640x480 frame including blanking so the CPU
// can poll the line and column and pace its frame updates.

`include "game_io_defs.svh"

module vga_scan_counter (
  input  logic                   clk,
  input  logic                   reset_n,
  output board_pkg::scan_count_t h_count,
  output board_pkg::scan_count_t v_count
);

  import board_pkg::*;

  localparam scan_count_t H_LAST = scan_count_t'(`VGA_H_TOTAL - 1);
  localparam scan_count_t V_LAST = scan_count_t'(`VGA_V_TOTAL - 1);

  logic h_wrap;  // Last pixel of the line.
  logic v_wrap;  // Last line of the frame.

  assign h_wrap = (h_count == H_LAST);
  assign v_wrap = (v_count == V_LAST);

  // One pixel per clock.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      h_count <= '0;
    end else if (h_wrap) begin
      h_count <= '0;
    end else begin
      h_count <= h_count + scan_count_t'(1);
    end
  end

  // Line count moves only when a line finishes.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      v_count <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        v_count <= '0;  // Back to the top of the frame.
      end else begin
        v_count <= v_count + scan_count_t'(1);
      end
    end
  end

endmodule

//--- source/io_mapping.sv
// Memory-mapped register block.
// Decodes CPU accesses against the peripheral map, holds the LED, display
// and music control registers, returns read data in the same cycle and
// drives the six seven-segment displays.

`include "game_io_defs.svh"

module io_mapping (
  input  logic                    clk,
  input  logic                    reset_n,
  input  bus_pkg::mem_req_t       mem_req,
  output bus_pkg::data_word_t     rd_data,
  input  board_pkg::board_in_t    board_in,
  input  board_pkg::scan_count_t  h_count,
  input  board_pkg::scan_count_t  v_count,
  output board_pkg::board_out_t   board_out
);

  import bus_pkg::*;
  import board_pkg::*;

  hex_digit_t  hex_q [6];   // Digit 0 is the rightmost display.
  led_t        ledr_q;
  music_ctrl_t music_q;
  seg7_t       seg [6];

  // Output registers. Only the register whose address matches is loaded.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < 6; i++) begin
        hex_q[i] <= '0;
      end
      ledr_q  <= '0;
      music_q <= '0;
    end else if (mem_req.wr_en) begin
      case (mem_req.addr)
        `HEX_L_ADDR: begin
          hex_q[0] <= mem_req.wr_data[3:0];
          hex_q[1] <= mem_req.wr_data[7:4];
          hex_q[2] <= mem_req.wr_data[11:8];
          hex_q[3] <= mem_req.wr_data[15:12];
        end
        `HEX_H_ADDR: begin
          hex_q[4] <= mem_req.wr_data[3:0];  // Upper byte is dropped.
          hex_q[5] <= mem_req.wr_data[7:4];
        end
        `LEDR_ADDR:       ledr_q  <= mem_req.wr_data[9:0];
        `MUSIC_CTRL_ADDR: music_q <= mem_req.wr_data[1:0];
        default: ;  // Read-only or unmapped.
      endcase
    end
  end

  // Read side. Narrow fields are zero-extended to the bus width.
  always_comb begin
    case (mem_req.addr)
      `SW_ADDR:         rd_data = data_word_t'(board_in.sw);
      `KEY_ADDR:        rd_data = data_word_t'(board_in.key);
      `DRUMPAD_ADDR:    rd_data = data_word_t'(board_in.drumpad);
      `LEDR_ADDR:       rd_data = data_word_t'(ledr_q);
      `HEX_L_ADDR:      rd_data = {hex_q[3], hex_q[2], hex_q[1], hex_q[0]};
      `HEX_H_ADDR:      rd_data = data_word_t'({hex_q[5], hex_q[4]});
      `VGA_HCOUNT_ADDR: rd_data = data_word_t'(h_count);
      `VGA_VCOUNT_ADDR: rd_data = data_word_t'(v_count);
      `MUSIC_CTRL_ADDR: rd_data = data_word_t'(music_q);
      default:          rd_data = '0;
    endcase
  end

  // One decoder per display.
  for (genvar d = 0; d < 6; d++) begin : g_seg
    hex_to_seg7 u_hex_to_seg7 (
      .digit (hex_q[d]),
      .seg   (seg[d])
    );
  end

  assign board_out.ledr       = ledr_q;
  assign board_out.hex0       = seg[0];
  assign board_out.hex1       = seg[1];
  assign board_out.hex2       = seg[2];
  assign board_out.hex3       = seg[3];
  assign board_out.hex4       = seg[4];
  assign board_out.hex5       = seg[5];
  assign board_out.music_ctrl = music_q;  // Straight to the synthesizer.

endmodule

//--- source/game_io_top.sv
// game_io peripheral block.
// Gives the CPU memory port access to the switches, keys, drum pads, LEDs,
// seven-segment displays, music control bits and the VGA scan position.

module game_io_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  bus_pkg::mem_req_t     mem_req,
  output bus_pkg::data_word_t   rd_data,
  input  board_pkg::board_in_t  board_pins,
  output board_pkg::board_out_t board_out
);

  import board_pkg::*;

  board_in_t   board_sync;  // Pins after the synchronizer.
  scan_count_t h_count;
  scan_count_t v_count;

  input_sync u_input_sync (
    .clk     (clk),
    .reset_n (reset_n),
    .raw     (board_pins),
    .synced  (board_sync)
  );

  vga_scan_counter u_vga_scan_counter (
    .clk     (clk),
    .reset_n (reset_n),
    .h_count (h_count),
    .v_count (v_count)
  );

  // The CPU request goes straight through to the register block.
  io_mapping u_io_mapping (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_req   (mem_req),
    .rd_data   (rd_data),
    .board_in  (board_sync),
    .h_count   (h_count),
    .v_count   (v_count),
    .board_out (board_out)
  );

endmodule

//--- tests/game_io_tb.sv
// game_io testbench.
// Reads operations and expected values from the stim file, drives the CPU
// bus and the board pins of game_io_top and checks read data and outputs
// against a register model kept from the memory map rules.

`include "game_io_defs.svh"

module game_io_tb;

  import bus_pkg::*;
  import board_pkg::*;

  localparam string STIM_FILE = "tests/game_io_stim.txt";

  logic       clk;
  logic       reset_n;
  mem_req_t   mem_req;
  data_word_t rd_data;
  board_in_t  board_pins;
  board_out_t board_out;

  string       rec_name [$];
  string       rec_op   [$];
  logic [31:0] rec_addr [$];
  logic [31:0] rec_data [$];
  logic [31:0] rec_exp  [$];

  led_t        led_m;     // Model of the LED register.
  music_ctrl_t music_m;
  hex_digit_t  hex_m [6];

  logic [31:0] lfsr_state = 32'h3189eac1;
  int          cycles_after_reset;
  int          cycle_count;
  int          cycle_limit;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  game_io_top u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .mem_req    (mem_req),
    .rd_data    (rd_data),
    .board_pins (board_pins),
    .board_out  (board_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle 1 is the first rising edge that sees reset released.
  always @(posedge clk) begin
    if (!reset_n) begin
      cycles_after_reset <= 0;
    end else begin
      cycles_after_reset <= cycles_after_reset + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  // Active-low glyphs, bits g down to a.
  function automatic seg7_t glyph(input hex_digit_t d);
    case (d)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  function automatic board_out_t expected_outputs();
    board_out_t o;
    o.ledr       = led_m;
    o.hex0       = glyph(hex_m[0]);
    o.hex1       = glyph(hex_m[1]);
    o.hex2       = glyph(hex_m[2]);
    o.hex3       = glyph(hex_m[3]);
    o.hex4       = glyph(hex_m[4]);
    o.hex5       = glyph(hex_m[5]);
    o.music_ctrl = music_m;
    return o;
  endfunction

  function automatic data_word_t model_readback(input addr_t addr);
    case (addr)
      `LEDR_ADDR:       return {6'b0, led_m};
      `MUSIC_CTRL_ADDR: return {14'b0, music_m};
      `HEX_L_ADDR:      return {hex_m[3], hex_m[2], hex_m[1], hex_m[0]};
      `HEX_H_ADDR:      return {8'b0, hex_m[5], hex_m[4]};
      default:          return '0;
    endcase
  endfunction

  task automatic model_write(input addr_t addr, input data_word_t data);
    case (addr)
      `LEDR_ADDR:       led_m = data[9:0];
      `MUSIC_CTRL_ADDR: music_m = data[1:0];
      `HEX_L_ADDR: begin
        for (int i = 0; i < 4; i++) begin
          hex_m[i] = data[4*i +: 4];
        end
      end
      `HEX_H_ADDR: begin
        hex_m[4] = data[3:0];
        hex_m[5] = data[7:4];
      end
      default: ;  // Read-only and unmapped addresses hold no state.
    endcase
  endtask

  // Fibonacci LFSR, taps 32 22 2 1.
  function automatic data_word_t random_word();
    data_word_t w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      w = {w[14:0], lfsr_state[0]};
    end
    return w;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("FAIL %0s expected %0h actual %0h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0s ok", name);
    end else begin
      tests_failed++;
      $display("test %0s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic bus_write(input addr_t addr, input data_word_t data);
    @(negedge clk);
    mem_req.addr    = addr;
    mem_req.wr_en   = 1'b1;
    mem_req.wr_data = data;
  endtask

  // Read data is combinational, so it is sampled mid low phase.
  task automatic bus_read(input addr_t addr, output data_word_t data);
    @(negedge clk);
    mem_req.addr    = addr;
    mem_req.wr_en   = 1'b0;
    mem_req.wr_data = '0;
    #5;
    data = rd_data;
  endtask

  task automatic write_and_check(input string name, input addr_t addr, input data_word_t data,
                                 input bit use_model, input data_word_t exp);
    data_word_t got;
    bus_write(addr, data);
    model_write(addr, data);
    bus_read(addr, got);
    check_eq(name, use_model ? model_readback(addr) : exp, got);
    check_eq({name, " board_out"}, expected_outputs(), board_out);
  endtask

  task automatic read_and_check(input string name, input addr_t addr, input data_word_t exp);
    data_word_t got;
    bus_read(addr, got);
    check_eq(name, exp, got);
    check_eq({name, " board_out"}, expected_outputs(), board_out);
  endtask

  task automatic apply_pins(input board_in_t pins);
    @(negedge clk);
    board_pins = pins;
    repeat (3) @(negedge clk);  // Covers the synchronizer delay.
  endtask

  task automatic scan_delta(input string name, input int n, input data_word_t exp);
    data_word_t first;
    data_word_t second;
    int         diff;
    bus_read(`VGA_HCOUNT_ADDR, first);
    repeat (n) @(negedge clk);
    #5;
    second = rd_data;
    diff = (int'(second) - int'(first) + `VGA_H_TOTAL) % `VGA_H_TOTAL;
    check_eq(name, exp, diff);
  endtask

  task automatic scan_absolute(input string name, input int at_cycle, input data_word_t exp);
    if (cycles_after_reset >= at_cycle) begin
      $display("Test %0s reached cycle %0d, already past its target cycle %0d",
               name, cycles_after_reset, at_cycle);
      test_errors++;
    end else begin
      @(negedge clk);
      mem_req.addr  = `VGA_VCOUNT_ADDR;
      mem_req.wr_en = 1'b0;
      while (cycles_after_reset < at_cycle) @(negedge clk);
      #5;
      check_eq(name, exp, rd_data);
    end
  endtask

  task automatic run_record(input int i);
    data_word_t rnd;
    if (rec_op[i] == "write") begin
      write_and_check(rec_name[i], rec_addr[i][15:0], rec_data[i][15:0], 1'b0, rec_exp[i][15:0]);
    end else if (rec_op[i] == "read") begin
      read_and_check(rec_name[i], rec_addr[i][15:0], rec_exp[i][15:0]);
    end else if (rec_op[i] == "pins") begin
      apply_pins(rec_data[i][17:0]);
    end else if (rec_op[i] == "scan" && rec_addr[i][15:0] == `VGA_HCOUNT_ADDR) begin
      scan_delta(rec_name[i], rec_data[i], rec_exp[i][15:0]);
    end else if (rec_op[i] == "scan") begin
      scan_absolute(rec_name[i], rec_data[i], rec_exp[i][15:0]);
    end else if (rec_op[i] == "rand") begin
      rnd = random_word();
      write_and_check(rec_name[i], rec_addr[i][15:0], rnd, 1'b1, '0);
    end else begin
      $display("Record %0s has an unknown operation %0s", rec_name[i], rec_op[i]);
      test_errors++;
    end
    finish_test(rec_name[i]);
  endtask

  task automatic load_records(output bit ok);
    int          fd;
    int          fields;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.substr(0, 0) != "#") begin
          fields = $sscanf(line, "%s %s %h %h %h", name, op, a, d, e);
          if (fields == 5) begin
            rec_name.push_back(name);
            rec_op.push_back(op);
            rec_addr.push_back(a);
            rec_data.push_back(d);
            rec_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
      ok = (rec_name.size() > 0);
    end
  endtask

  initial begin
    bit loaded;
    mem_req    = '0;
    board_pins = '0;
    reset_n    = 1'b0;
    led_m      = '0;
    music_m    = '0;
    for (int i = 0; i < 6; i++) begin
      hex_m[i] = '0;
    end
    load_records(loaded);
    if (!loaded) begin
      $display("Could not read any records from %0s", STIM_FILE);
      $display("Regression failed");
      $finish;
    end else begin
      cycle_limit = 4 * rec_name.size() + 100 + 10;  // Reset cycles included.
      foreach (rec_op[i]) begin
        if (rec_op[i] == "scan") cycle_limit += rec_data[i];
      end
      repeat (10) @(negedge clk);
      reset_n = 1'b1;
      @(negedge clk);
      #5;
      check_eq("reset_outputs", expected_outputs(), board_out);
      finish_test("reset_outputs");
      for (int i = 0; i < rec_name.size(); i++) begin
        run_record(i);
      end
      $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (tests_failed == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

//--- game_io.f
+incdir+source
source/bus_pkg.sv
source/board_pkg.sv
source/hex_to_seg7.sv
source/input_sync.sv
source/vga_scan_counter.sv
source/io_mapping.sv
source/game_io_top.sv
tests/game_io_tb.sv

//--- tests/game_io_stim.txt
# Columns: test name, operation (write read pins scan rand), address, data, expected.
# Values in hex. Pins data is {sw, key, drumpad}; scan data is a cycle count.
rst_ledr    read  FFFD 0000  0000
rst_hexl    read  FFFB 0000  0000
rst_hexh    read  FFFC 0000  0000
rst_music   read  FFF8 0000  0000
ledr_all    write FFFD FFFF  03FF
ledr_val    write FFFD 0155  0155
ledr_mask   write FFFD FC2A  002A
music_all   write FFF8 FFFF  0003
music_val   write FFF8 0001  0001
hexl_seq    write FFFB 3210  3210
hexl_top    write FFFB FEDC  FEDC
hexl_mix    write FFFB 9A5B  9A5B
hexh_val    write FFFC 0054  0054
hexh_mask   write FFFC ABCD  00CD
hexh_hi     write FFFC 00F6  00F6
hexl_last   write FFFB 8E71  8E71
ro_sw       write FFFF 03FF  0000
ro_key      write FFFE 000F  0000
ro_pad      write FFF7 000F  0000
ro_vcount   write FFF9 1234  0000
un_low      write 0000 BEEF  0000
un_fff6     write FFF6 FFFF  0000
un_mid      write 8000 1234  0000
hold_ledr   read  FFFD 0000  002A
hold_music  read  FFF8 0000  0001
hold_hexl   read  FFFB 0000  8E71
hold_hexh   read  FFFC 0000  00F6
un_read0    read  0000 0000  0000
un_readf6   read  FFF6 0000  0000
pins_a      pins  0000 2A5C3 0000
sw_a        read  FFFF 0000  02A5
key_a       read  FFFE 0000  000C
pad_a       read  FFF7 0000  0003
pins_b      pins  0000 3FFFF 0000
sw_b        read  FFFF 0000  03FF
key_b       read  FFFE 0000  000F
pad_b       read  FFF7 0000  000F
pins_c      pins  0000 00A96 0000
sw_c        read  FFFF 0000  000A
key_c       read  FFFE 0000  0009
pad_c       read  FFF7 0000  0006
ro_sw_pins  write FFFF 0000  000A
h_short     scan  FFFA 0005  0005
h_wrap      scan  FFFA 0384  0064
v_abs       scan  FFF9 0672  0002
rnd_ledr    rand  FFFD 0000  0000
rnd_music   rand  FFF8 0000  0000
rnd_hexl    rand  FFFB 0000  0000
rnd_hexh    rand  FFFC 0000  0000
rnd_ledr2   rand  FFFD 0000  0000
rnd_hexl2   rand  FFFB 0000  0000
rnd_music2  rand  FFF8 0000  0000
rnd_hexh2   rand  FFFC 0000  0000
